//--- common/fp_format_pkg.sv
`default_nettype none

package fp_format_pkg;

    localparam int EXP_W    = 8;                   // Biased exponent field
    localparam int MAN_W    = 23;                  // Stored fraction, implicit one dropped
    localparam int WORD_W   = 1 + EXP_W + MAN_W;   // 32
    localparam int EXP_BIAS = 127;

    // Any operand with the sign bit set maps to this word
    localparam logic [WORD_W-1:0] NEG_RESULT = {WORD_W{1'b1}};

    // Same 32 bits seen as a raw word or as its fields
    typedef union packed {
        logic [WORD_W-1:0] raw;
        struct packed {
            logic             sign;
            logic [EXP_W-1:0] exp;    // Biased
            logic [MAN_W-1:0] man;    // HUB fraction, ILSB implied
        } f;
    } fp_word_t;

endpackage

`default_nettype wire

//--- common/sqrt_alg_pkg.sv
`default_nettype none

package sqrt_alg_pkg;

    // Remainder fixed point: sign, 3 integer bits, 25 fraction bits
    localparam int RES_W = 29;
    localparam int EST_W = 4;                      // Top bits fed to digit selection

    localparam int ROOT_W     = 24;                // Root incl. implicit one
    localparam int ITER_COUNT = ROOT_W - 1;        // First digit is preset on load
    localparam int STEP_W     = $clog2(ITER_COUNT);

    // Signed root digits, two bit codes
    localparam logic [1:0] DIGIT_ZERO = 2'b00;
    localparam logic [1:0] DIGIT_POS  = 2'b01;
    localparam logic [1:0] DIGIT_NEG  = 2'b11;

    // Control FSM encoding
    localparam int STATE_W = 2;
    localparam logic [STATE_W-1:0] ST_IDLE   = 2'd0;
    localparam logic [STATE_W-1:0] ST_ITER   = 2'd1;
    localparam logic [STATE_W-1:0] ST_FINISH = 2'd2;
    localparam logic [STATE_W-1:0] ST_HOLD   = 2'd3;

endpackage

`default_nettype wire

//--- rtl/operand_unpack.sv
`timescale 1ns/1ps
`default_nettype none

module operand_unpack
    import fp_format_pkg::*, sqrt_alg_pkg::*;
(
    input  wire fp_word_t     in_word,
    output logic [RES_W-1:0]  radicand,
    output logic [EXP_W-1:0]  res_exp,
    output logic              is_negative
);

    logic [MAN_W+1:0]        hub_sig;     // 1.man plus ILSB
    logic signed [EXP_W+1:0] unb_exp;     // Two guard bits for the sign
    logic signed [EXP_W+1:0] half_exp;
    logic                    exp_odd;

    assign is_negative = in_word.f.sign;

    // Implicit one, stored fraction, HUB ILSB always one
    assign hub_sig = {1'b1, in_word.f.man, 1'b1};

    assign unb_exp  = {2'b00, in_word.f.exp} - (EXP_W+2)'(EXP_BIAS);
    assign exp_odd  = unb_exp[0];
    assign half_exp = unb_exp >>> 1;      // Floor, also for negative exponents

    assign res_exp = EXP_W'(half_exp + (EXP_W+2)'(EXP_BIAS));

    // radicand holds 2x with x in [1/4, 1), unit 2^-25
    // Odd exponent folds its leftover factor of two into the significand
    always_comb begin
        if (exp_odd) begin
            radicand = {{(RES_W-MAN_W-3){1'b0}}, hub_sig, 1'b0};
        end else begin
            radicand = {{(RES_W-MAN_W-2){1'b0}}, hub_sig};
        end
    end

endmodule

`default_nettype wire

//--- rtl/sqrt_control.sv
`timescale 1ns/1ps
`default_nettype none

module sqrt_control
    import fp_format_pkg::*, sqrt_alg_pkg::*;
(
    input  wire               clk,
    input  wire               rst_l,
    input  wire               in_valid,
    output logic              in_ready,
    input  wire               is_negative,
    output logic              out_valid,
    input  wire               out_ready,
    input  wire fp_word_t     final_word,
    output fp_word_t          out_word,
    output logic              load,
    output logic              step,
    output logic [STEP_W-1:0] step_idx
);

    logic [STATE_W-1:0] state;
    logic [STEP_W-1:0]  step_cnt;
    logic               accept;
    logic               done_pulse;
    logic               last_step;

    assign in_ready   = (state == ST_IDLE);
    assign out_valid  = (state == ST_HOLD);
    assign accept     = in_valid && in_ready;
    assign load       = accept && !is_negative;   // Negative operands skip the datapath
    assign step       = (state == ST_ITER);
    assign done_pulse = (state == ST_FINISH);
    assign step_idx   = step_cnt;
    assign last_step  = (step_cnt == STEP_W'(ITER_COUNT - 1));

    always_ff @(posedge clk or negedge rst_l) begin
        if (!rst_l) begin
            state    <= ST_IDLE;
            step_cnt <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (accept) begin
                        step_cnt <= '0;
                        state    <= is_negative ? ST_HOLD : ST_ITER;
                    end
                end
                ST_ITER: begin
                    step_cnt <= step_cnt + 1'b1;   // One digit per cycle
                    if (last_step) begin
                        state <= ST_FINISH;
                    end
                end
                ST_FINISH: begin
                    state <= ST_HOLD;              // Result word captured this cycle
                end
                ST_HOLD: begin
                    if (out_ready) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Result holding register, stable for the whole HOLD state
    always_ff @(posedge clk) begin
        if (accept && is_negative) begin
            out_word.raw <= NEG_RESULT;
        end else if (done_pulse) begin
            out_word <= final_word;
        end
    end

endmodule

`default_nettype wire

//--- sqrt_iter/residual_update.sv
`timescale 1ns/1ps
`default_nettype none

module residual_update
    import fp_format_pkg::*, sqrt_alg_pkg::*;
(
    input  wire              clk,
    input  wire              rst_l,
    input  wire              load,
    input  wire              step,
    input  wire [RES_W-1:0]  radicand,
    input  wire [EXP_W-1:0]  res_exp,
    input  wire [RES_W-1:0]  f_pos,     // Subtracted for digit +1
    input  wire [RES_W-1:0]  f_neg,     // Added for digit -1
    output logic [1:0]       digit,
    output logic [RES_W-1:0] res_sum,
    output logic [RES_W-1:0] res_carry,
    output logic [EXP_W-1:0] held_exp
);

    logic [RES_W-1:0] sum_sh;
    logic [RES_W-1:0] carry_sh;
    logic [EST_W-1:0] estimate;
    logic [RES_W-1:0] addend;
    logic             carry_in;
    logic [RES_W-1:0] csa_sum;
    logic [RES_W-1:0] csa_maj;

    // 2w, top bits falling off are harmless in mod 2^RES_W arithmetic
    assign sum_sh   = res_sum << 1;
    assign carry_sh = res_carry << 1;

    // Truncated sum of both halves, error below two units of 1
    assign estimate = sum_sh[RES_W-1 -: EST_W] + carry_sh[RES_W-1 -: EST_W];

    always_comb begin
        if (estimate == {EST_W{1'b1}}) begin
            digit = DIGIT_ZERO;             // 2w in [-1, 1)
        end else if (!estimate[EST_W-1]) begin
            digit = DIGIT_POS;              // 2w >= 0
        end else begin
            digit = DIGIT_NEG;              // 2w < 0
        end
    end

    // Subtraction for +1 as inverted term plus one ulp at the carry LSB
    assign addend   = (digit == DIGIT_POS) ? ~f_pos : f_neg;
    assign carry_in = (digit == DIGIT_POS);

    // 3:2 carry-save add
    assign csa_sum = sum_sh ^ carry_sh ^ addend;
    assign csa_maj = (sum_sh & carry_sh) | (sum_sh & addend) | (carry_sh & addend);

    always_ff @(posedge clk or negedge rst_l) begin
        if (!rst_l) begin
            res_sum   <= '0;
            res_carry <= '0;
        end else if (load) begin
            // First digit preset to one: w1 = 2x - 1/2
            res_sum   <= radicand;
            res_carry <= {RES_W{1'b1}} << ROOT_W;          // -1/2
        end else if (step) begin
            if (digit == DIGIT_ZERO) begin
                res_sum   <= sum_sh;                      // Plain shift
                res_carry <= carry_sh;
            end else begin
                res_sum   <= csa_sum;
                res_carry <= {csa_maj[RES_W-2:0], carry_in};
            end
        end
    end

    // Result exponent kept alongside the remainder
    always_ff @(posedge clk) begin
        if (load) begin
            held_exp <= res_exp;
        end
    end

endmodule

`default_nettype wire

//--- sqrt_iter/otf_root.sv
`timescale 1ns/1ps
`default_nettype none

module otf_root
    import sqrt_alg_pkg::*;
(
    input  wire               clk,
    input  wire               rst_l,
    input  wire               load,
    input  wire               step,
    input  wire [STEP_W-1:0]  step_idx,
    input  wire [1:0]         digit,
    output logic [ROOT_W-1:0] root_q,    // Q, unit 2^-24
    output logic [ROOT_W-1:0] root_qm,   // Q minus one ulp of the current step
    output logic [RES_W-1:0]  f_pos,
    output logic [RES_W-1:0]  f_neg
);

    logic [STEP_W-1:0] bit_pos;
    logic [ROOT_W-1:0] pos_mask;     // Weight of the digit being produced

    // Step 0 produces root bit ROOT_W-2, the last step bit 0
    assign bit_pos  = STEP_W'(ROOT_W - 2) - step_idx;
    assign pos_mask = {{(ROOT_W-1){1'b0}}, 1'b1} << bit_pos;

    // In remainder units 2Q sits at root << 2, the new digit weight at mask << 1
    // All pieces are disjoint so OR replaces the adds
    assign f_pos = {{(RES_W-ROOT_W-2){1'b0}},
                    {root_q, 2'b00} | {1'b0, pos_mask, 1'b0}};          // 2Q + d
    assign f_neg = {{(RES_W-ROOT_W-2){1'b0}},
                    {root_qm, 2'b00} | {pos_mask, 2'b00} | {1'b0, pos_mask, 1'b0}};
                                                                        // 2Q - d

    always_ff @(posedge clk or negedge rst_l) begin
        if (!rst_l) begin
            root_q  <= '0;
            root_qm <= '0;
        end else if (load) begin
            root_q  <= {1'b1, {(ROOT_W-1){1'b0}}};   // Preset digit, Q = 1/2
            root_qm <= '0;
        end else if (step) begin
            case (digit)
                DIGIT_POS: begin
                    root_q  <= root_q | pos_mask;
                    root_qm <= root_q;
                end
                DIGIT_ZERO: begin
                    root_qm <= root_qm | pos_mask;   // Q unchanged
                end
                DIGIT_NEG: begin
                    root_q  <= root_qm | pos_mask;   // QM unchanged
                end
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- rtl/root_finalize.sv
`timescale 1ns/1ps
`default_nettype none

module root_finalize
    import fp_format_pkg::*, sqrt_alg_pkg::*;
(
    input  wire [RES_W-1:0]  res_sum,
    input  wire [RES_W-1:0]  res_carry,
    input  wire [ROOT_W-1:0] root_q,
    input  wire [ROOT_W-1:0] root_qm,
    input  wire [EXP_W-1:0]  res_exp,
    output fp_word_t         final_word
);

    logic [RES_W-1:0]  rem_full;    // Resolved final remainder
    logic              rem_neg;
    logic [ROOT_W-1:0] root_sel;

    assign rem_full = res_sum + res_carry;
    assign rem_neg  = rem_full[RES_W-1];

    // Negative remainder means Q overshot by one ulp
    assign root_sel = rem_neg ? root_qm : root_q;

    // Root lies in [1, 2) so its MSB is always the implicit one
    always_comb begin
        final_word.f.sign = 1'b0;
        final_word.f.exp  = res_exp;
        final_word.f.man  = root_sel[MAN_W-1:0];
    end

endmodule

`default_nettype wire

//--- rtl/fphub_sqrt.sv
`timescale 1ns/1ps
`default_nettype none

module fphub_sqrt
    import fp_format_pkg::*, sqrt_alg_pkg::*;
(
    input  wire           clk,
    input  wire           rst_l,
    input  wire           in_valid,
    output logic          in_ready,
    input  wire fp_word_t in_word,
    output logic          out_valid,
    input  wire           out_ready,
    output fp_word_t      out_word
);

    logic [RES_W-1:0]  radicand;    // 2x, unit 2^-25
    logic [EXP_W-1:0]  res_exp;     // Straight from the operand
    logic [EXP_W-1:0]  held_exp;    // Captured on load
    logic              is_negative;

    logic              load;
    logic              step;
    logic [STEP_W-1:0] step_idx;

    logic [1:0]        digit;
    logic [RES_W-1:0]  f_pos;
    logic [RES_W-1:0]  f_neg;
    logic [RES_W-1:0]  res_sum;
    logic [RES_W-1:0]  res_carry;
    logic [ROOT_W-1:0] root_q;
    logic [ROOT_W-1:0] root_qm;
    fp_word_t          final_word;

    operand_unpack u_unpack (
        .in_word     (in_word),
        .radicand    (radicand),
        .res_exp     (res_exp),
        .is_negative (is_negative)
    );

    sqrt_control u_ctrl (
        .clk         (clk),
        .rst_l       (rst_l),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .is_negative (is_negative),
        .out_valid   (out_valid),
        .out_ready   (out_ready),
        .final_word  (final_word),
        .out_word    (out_word),
        .load        (load),
        .step        (step),
        .step_idx    (step_idx)
    );

    residual_update u_res (
        .clk       (clk),
        .rst_l     (rst_l),
        .load      (load),
        .step      (step),
        .radicand  (radicand),
        .res_exp   (res_exp),
        .f_pos     (f_pos),
        .f_neg     (f_neg),
        .digit     (digit),
        .res_sum   (res_sum),
        .res_carry (res_carry),
        .held_exp  (held_exp)
    );

    otf_root u_otf (
        .clk      (clk),
        .rst_l    (rst_l),
        .load     (load),
        .step     (step),
        .step_idx (step_idx),
        .digit    (digit),
        .root_q   (root_q),
        .root_qm  (root_qm),
        .f_pos    (f_pos),
        .f_neg    (f_neg)
    );

    root_finalize u_fin (
        .res_sum    (res_sum),
        .res_carry  (res_carry),
        .root_q     (root_q),
        .root_qm    (root_qm),
        .res_exp    (held_exp),
        .final_word (final_word)
    );

endmodule

`default_nettype wire

//--- tests/sqrt_ref.svh
`ifndef SQRT_REF_SVH
`define SQRT_REF_SVH

// Bitwise integer square root giving floor of sqrt(v)
function automatic logic [63:0] int_sqrt(input logic [63:0] v);
    logic [63:0] num;
    logic [63:0] res;
    logic [63:0] b;
    num = v;
    res = '0;
    b   = 64'h4000_0000_0000_0000;   // Highest power of four
    for (int i = 0; i < 32; i++) begin
        if (num >= res + b) begin
            num = num - (res + b);
            res = (res >> 1) + b;
        end else begin
            res = res >> 1;
        end
        b = b >> 2;
    end
    return res;
endfunction

// Expected packed root word for one operand
function automatic logic [31:0] expected_root_word(input logic [31:0] op);
    int          e;
    int          half;
    logic [24:0] sig;
    logic [63:0] r;
    logic [63:0] root;
    logic [7:0]  er;
    if (op[31]) begin
        return 32'hffff_ffff;            // Any negative operand
    end
    e   = int'(op[30:23]) - 127;
    sig = {1'b1, op[22:0], 1'b1};        // Implicit one, fraction, ILSB
    r   = {39'd0, sig};
    if (e % 2 != 0) begin
        r    = r << 1;                   // Odd exponent doubles R
        half = (e - 1) / 2;              // Exact division gives the floor
    end else begin
        half = e / 2;
    end
    root = int_sqrt(r << 22);            // 24-bit root with top bit set
    er   = 8'(half + 127);
    return {1'b0, er, root[22:0]};
endfunction

`endif

//--- tests/tb_fphub_sqrt.sv
`timescale 1ns/1ps
`default_nettype none

module tb_fphub_sqrt
    import fp_format_pkg::*;
();

    logic     clk;
    logic     rst_l;
    logic     in_valid;
    logic     in_ready;
    fp_word_t in_word;
    logic     out_valid;
    logic     out_ready;
    fp_word_t out_word;

    int          seed = 32'hdb12_30e2;
    int          errors = 0;
    int          failed_tests = 0;
    int          cycle_cnt = 0;
    int          max_cycles = 0;    // Set once the operand list is known
    logic [31:0] ops[$];
    int          gaps[$];

    // Scoreboard state, all updated on the clock
    logic        busy;              // Operand accepted, result not yet out
    logic [31:0] exp_word;          // Expected result of the operand in flight
    logic        first_cycle;
    logic        stalled_prev;      // Last edge had out_valid without out_ready
    logic [31:0] word_prev;

    fphub_sqrt dut0 (
        .clk       (clk),
        .rst_l     (rst_l),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_word   (in_word),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_word  (out_word)
    );

    always #4 clk = ~clk;           // 8 ns period

    task automatic report_error(input string msg);
        errors = errors + 1;
        $display("[ERROR] %0t: %s", $time, msg);
    endtask

    always @(posedge clk) begin
        first_cycle <= !rst_l;      // High in the first cycle after release
        if (!rst_l) begin
            busy         <= 1'b0;
            stalled_prev <= 1'b0;
            exp_word     <= '0;
        end else begin
            if (in_valid && in_ready) begin
                busy     <= 1'b1;
                exp_word <= expected_root_word(in_word.raw);
            end else if (out_valid && out_ready) begin
                busy <= 1'b0;
            end
            stalled_prev <= out_valid && !out_ready;
            word_prev    <= out_word.raw;
        end
    end

    // Random backpressure, about one cycle in four
    always @(posedge clk) begin
        if (rst_l) begin
            out_ready <= (($random(seed) & 3) != 0);
        end
    end

    reset_idle_chk: assert property (@(posedge clk) disable iff (!rst_l)
        first_cycle |-> (in_ready && !out_valid))
        else report_error("in_ready low or out_valid high right after reset");

    result_value_chk: assert property (@(posedge clk) disable iff (!rst_l)
        out_valid |-> (out_word.raw == exp_word))
        else report_error($sformatf("result %h, expected %h", out_word.raw, exp_word));

    hold_stable_chk: assert property (@(posedge clk) disable iff (!rst_l)
        stalled_prev |-> (out_valid && out_word.raw == word_prev))
        else report_error("out_word or out_valid changed during a stall");

    ready_low_chk: assert property (@(posedge clk) disable iff (!rst_l)
        busy |-> !in_ready)
        else report_error("in_ready high while an operand is in flight");

    one_result_chk: assert property (@(posedge clk) disable iff (!rst_l)
        out_valid |-> busy)
        else report_error("out_valid without a pending operand");

    // Hang guard
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (max_cycles > 0 && cycle_cnt >= max_cycles) begin
            $display("Timeout: the run hung, no progress after %0d cycles", cycle_cnt);
            $display("TEST FAILED");
            $finish;
        end
    end

    // One operand through both handshakes
    task automatic run_op(input int idx, input logic [31:0] op, input int gap);
        int          err_before;
        logic [31:0] got;
        err_before = errors;
        repeat (gap) @(posedge clk);
        @(negedge clk);
        while (!in_ready) @(negedge clk);
        @(posedge clk);
        in_valid    <= 1'b1;
        in_word.raw <= op;
        @(negedge clk);
        while (!in_ready) @(negedge clk);
        @(posedge clk);             // Transfer on this edge
        in_valid <= 1'b0;
        @(negedge clk);
        while (!(out_valid && out_ready)) @(negedge clk);
        got = out_word.raw;
        @(posedge clk);             // Output transfer
        @(negedge clk);             // Checks of that edge are done
        if (errors != err_before) begin
            failed_tests = failed_tests + 1;
        end
        $display("test %0d: operand %h result %h expected %h %s", idx, op, got, exp_word,
                 (errors == err_before) ? "pass" : "fail");
    endtask

    initial begin
        logic [31:0] word;
        int          ex;
        clk         = 1'b0;
        rst_l       = 1'b0;
        in_valid    = 1'b0;
        in_word.raw = '0;
        out_ready   = 1'b0;

        // Directed operands
        ops.push_back(32'h3f80_0000);   // 1.0
        ops.push_back(32'h4080_0000);   // 4.0
        ops.push_back(32'h4000_0000);   // 2.0
        ops.push_back(32'h3fff_ffff);   // Mantissa all ones, even exponent
        ops.push_back(32'h407f_ffff);   // Mantissa all ones, odd exponent
        ops.push_back(32'h3fc0_0000);   // 1.5
        ops.push_back(32'h4040_0000);   // 3.0
        ops.push_back(32'h0080_0000);   // Exponent 1
        ops.push_back(32'h00ff_ffff);
        ops.push_back(32'h0100_0000);   // Exponent 2, odd unbiased
        ops.push_back(32'h7f00_0000);   // Exponent 254
        ops.push_back(32'h7f7f_ffff);
        ops.push_back(32'hbf80_0000);   // Negative ones
        ops.push_back(32'hc049_0fdb);
        ops.push_back(32'hff7f_ffff);
        for (int i = 0; i < 200; i++) begin
            word = $random(seed);
            ex   = ($random(seed) & 32'h7fff_ffff) % 254 + 1;
            ops.push_back({1'b0, ex[7:0], word[22:0]});
        end
        for (int i = 0; i < ops.size(); i++) begin
            gaps.push_back($random(seed) & 3);   // Idle cycles before each operand
        end
        max_cycles = ops.size() * 40 + 100;

        repeat (3) @(posedge clk);
        rst_l <= 1'b1;
        @(posedge clk);

        for (int i = 0; i < ops.size(); i++) begin
            run_op(i, ops[i], gaps[i]);
        end

        $display("summary: %0d tests, %0d failed, %0d errors", ops.size(), failed_tests,
                 errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    `include "sqrt_ref.svh"

endmodule

`default_nettype wire

//--- fphub_sqrt.f
+incdir+tests
common/fp_format_pkg.sv
common/sqrt_alg_pkg.sv
rtl/operand_unpack.sv
rtl/sqrt_control.sv
sqrt_iter/residual_update.sv
sqrt_iter/otf_root.sv
rtl/root_finalize.sv
rtl/fphub_sqrt.sv
tests/tb_fphub_sqrt.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the fphub_sqrt testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f fphub_sqrt.f \
    --top-module tb_fphub_sqrt \
    -Mdir obj_dir

out=$(./obj_dir/Vtb_fphub_sqrt)
printf '%s\n' "$out"

# Pass only when the pass line is present
printf '%s\n' "$out" | grep -qx 'TEST OK'
